// ==== alu.sv ====
/* Combinational integer ALU with logic, add, subtract, shift and
   multiply functions, returning result, high word and flags. */
`timescale 1ns/1ps
`include "alu_cfg.svh"

module alu #(
  parameter int WIDTH = `ALU_WIDTH
) (
  input  logic [WIDTH-1:0]         in1,
  input  logic [WIDTH-1:0]         in2,
  input  alu_ops_pkg::alu_func_e   func,
  input  logic                     c_in,
  input  logic                     z_in,
  output logic [WIDTH-1:0]         out,
  output logic [WIDTH-1:0]         out_long,
  output alu_ops_pkg::alu_flags_t  flags
);
  import alu_ops_pkg::*;

  logic [2*WIDTH-1:0] mul_s;
  logic [2*WIDTH-1:0] mul_u;
  logic [WIDTH-1:0]   res;
  logic [WIDTH-1:0]   res_hi;
  logic               c;
  logic               v;
  logic               n;
  logic               a_msb;
  logic               b_msb;

  assign mul_s = $signed(in1) * $signed(in2);
  assign mul_u = in1 * in2;

  assign a_msb = in1[WIDTH-1];
  assign b_msb = in2[WIDTH-1];

  always_comb begin
    res_hi = '0;
    c      = c_in;
    v      = 1'b0;
    case (func)
      ALU_AND: res = in1 & in2;
      ALU_OR:  res = in1 | in2;
      ALU_XOR: res = in1 ^ in2;
      ALU_ADD: begin
        {c, res} = {1'b0, in1} + {1'b0, in2} + (WIDTH + 1)'(c_in); // True carry out.
        v = (a_msb & b_msb & ~res[WIDTH-1]) | (~a_msb & ~b_msb & res[WIDTH-1]);
      end
      ALU_SUB: begin
        {c, res} = {1'b0, in1} - {1'b0, in2}; // C is the borrow.
        v = (a_msb & ~b_msb & ~res[WIDTH-1]) | (~a_msb & b_msb & res[WIDTH-1]);
      end
      ALU_LSHIFT: begin
        {c, res} = {1'b0, in1} << in2;
        v = res[WIDTH-1] ^ c;
      end
      ALU_RSHIFTA: begin
        res = $signed(in1) >>> in2;
        c   = 1'b0;
        v   = res[WIDTH-1];
      end
      ALU_RSHIFTL: begin
        res = in1 >> in2;
        c   = 1'b0;
        v   = res[WIDTH-1];
      end
      ALU_MUL: begin
        {res_hi, res} = mul_s;
        c = 1'b0;
      end
      ALU_MULU: begin
        {res_hi, res} = mul_u;
        c = 1'b0;
      end
      default: res = in1; // Pass-through for codes 10 to 15.
    endcase
  end

  assign n = res[WIDTH-1];

  assign out      = res;
  assign out_long = res_hi;
  assign flags.c  = c;
  assign flags.z  = ~|{res, z_in}; // z_in high blocks Z.
  assign flags.n  = n;
  assign flags.v  = v;

endmodule

// ==== alu_cfg.svh ====
/* Width and depth defines for the ALU unit. */
`ifndef ALU_CFG_SVH
`define ALU_CFG_SVH

// Operand and result width.
`define ALU_WIDTH 32

// Command buffer depth, also the source credits after reset.
`define ALU_CMD_DEPTH 4

// Response buffer depth.
`define ALU_RSP_DEPTH 4

// Width of the command tag.
`define ALU_TAG_W 4

`endif

// ==== alu_decode.sv ====
/* Command buffer, credit return and function code decoding. */
`timescale 1ns/1ps
`include "alu_cfg.svh"

module alu_decode (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic                    cmd_valid,
  input  alu_link_pkg::alu_cmd_t  cmd,
  output logic                    cmd_credit,
  input  logic                    exe_ready,
  output logic                    op_valid,
  output alu_ops_pkg::alu_op_t    op,
  output logic [`ALU_WIDTH-1:0]   in1,
  output logic [`ALU_WIDTH-1:0]   in2
);
  import alu_ops_pkg::*;
  import alu_link_pkg::*;

  alu_cmd_t head;
  alu_op_t  dec;
  logic     empty;
  logic     pop;

  // Source never overruns, it only sends against credits.
  credit_fifo #(
    .payload_t (alu_cmd_t),
    .DEPTH     (`ALU_CMD_DEPTH)
  ) u_cmd_fifo (
    .clk      (clk),
    .arst_n   (arst_n),
    .push     (cmd_valid),
    .din      (cmd),
    .pop      (pop),
    .dout     (head),
    .empty    (empty),
    .free_cnt ()
  );

  assign pop = exe_ready && !empty;

  always_comb begin
    dec.func      = alu_func_e'(head.func); // Undefined codes hit the ALU pass-through.
    dec.use_flags = head.use_flags;
    dec.tag       = head.tag;
    case (head.func)
      ALU_AND, ALU_OR, ALU_XOR, ALU_ADD, ALU_SUB,
      ALU_LSHIFT, ALU_RSHIFTA, ALU_RSHIFTL,
      ALU_MUL, ALU_MULU: dec.illegal = 1'b0;
      default:           dec.illegal = 1'b1;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      op_valid   <= 1'b0;
      cmd_credit <= 1'b0;
    end else begin
      op_valid   <= pop;
      cmd_credit <= pop; // One credit per freed slot.
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      op  <= dec;
      in1 <= head.in1;
      in2 <= head.in2;
    end
  end

endmodule

// ==== alu_execute.sv ====
/* Registered execute stage with the ALU and the carry/zero flag register. */
`timescale 1ns/1ps
`include "alu_cfg.svh"

module alu_execute (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic                    op_valid,
  input  alu_ops_pkg::alu_op_t    op,
  input  logic [`ALU_WIDTH-1:0]   in1,
  input  logic [`ALU_WIDTH-1:0]   in2,
  output logic                    res_valid,
  output alu_link_pkg::alu_rsp_t  res
);
  import alu_ops_pkg::*;

  alu_flags_t             flags_q;
  alu_flags_t             alu_flags;
  logic [`ALU_WIDTH-1:0]  out;
  logic [`ALU_WIDTH-1:0]  out_long;
  logic                   c_in;
  logic                   z_in;

  // Flag chaining only when the command asks for it.
  assign c_in = op.use_flags & flags_q.c;
  assign z_in = op.use_flags & ~flags_q.z;

  alu #(
    .WIDTH (`ALU_WIDTH)
  ) u_alu (
    .in1      (in1),
    .in2      (in2),
    .func     (op.func),
    .c_in     (c_in),
    .z_in     (z_in),
    .out      (out),
    .out_long (out_long),
    .flags    (alu_flags)
  );

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      res_valid <= 1'b0;
      flags_q   <= '0;
    end else begin
      res_valid <= op_valid;
      if (op_valid) flags_q <= alu_flags;
    end
  end

  always_ff @(posedge clk) begin
    if (op_valid) begin
      res.tag     <= op.tag;
      res.result  <= out;
      res.high    <= out_long;
      res.flags   <= alu_flags;
      res.illegal <= op.illegal;
    end
  end

endmodule

// ==== alu_link_pkg.sv ====
/* Command and response records of the two credit links. */
`include "alu_cfg.svh"

package alu_link_pkg;

  // Raw command, function code not yet checked.
  typedef struct packed {
    logic [3:0]             func;
    logic [`ALU_WIDTH-1:0]  in1;
    logic [`ALU_WIDTH-1:0]  in2;
    logic                   use_flags;
    logic [`ALU_TAG_W-1:0]  tag;
  } alu_cmd_t;

  typedef struct packed {
    logic [`ALU_TAG_W-1:0]  tag;
    logic [`ALU_WIDTH-1:0]  result;
    logic [`ALU_WIDTH-1:0]  high;    // Upper product word.
    alu_ops_pkg::alu_flags_t flags;
    logic                   illegal;
  } alu_rsp_t;

endpackage

// ==== alu_ops_pkg.sv ====
/* Instruction encoding of the ALU unit: function codes, decoded
   operation and condition flags. */
`include "alu_cfg.svh"

package alu_ops_pkg;

  // Function codes as used by the ALU datapath.
  typedef enum logic [3:0] {
    ALU_AND     = 4'h0,
    ALU_OR      = 4'h1,
    ALU_ADD     = 4'h2,
    ALU_SUB     = 4'h3,
    ALU_LSHIFT  = 4'h4,
    ALU_RSHIFTA = 4'h5,
    ALU_RSHIFTL = 4'h6,
    ALU_XOR     = 4'h7,
    ALU_MUL     = 4'h8,
    ALU_MULU    = 4'h9
  } alu_func_e;

  typedef struct packed {
    logic c; // Carry or borrow.
    logic z; // Zero.
    logic n; // Negative, result MSB.
    logic v; // Signed overflow.
  } alu_flags_t;

  typedef struct packed {
    alu_func_e              func;
    logic                   illegal;   // Code 10 to 15.
    logic                   use_flags; // Chain stored C and Z.
    logic [`ALU_TAG_W-1:0]  tag;
  } alu_op_t;

endpackage

// ==== alu_result.sv ====
/* Response buffer, downstream credit counter and execute back-pressure. */
`timescale 1ns/1ps
`include "alu_cfg.svh"

module alu_result (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic                    res_valid,
  input  alu_link_pkg::alu_rsp_t  res,
  output logic                    exe_ready,
  input  logic                    rsp_credit,
  output logic                    rsp_valid,
  output alu_link_pkg::alu_rsp_t  rsp
);
  import alu_link_pkg::*;

  localparam int FREE_W = $clog2(`ALU_RSP_DEPTH + 1);
  localparam int CRD_W  = 8;

  logic [FREE_W-1:0] free_cnt;
  logic [CRD_W-1:0]  credit_cnt;
  logic              empty;
  logic              send;

  credit_fifo #(
    .payload_t (alu_rsp_t),
    .DEPTH     (`ALU_RSP_DEPTH)
  ) u_rsp_fifo (
    .clk      (clk),
    .arst_n   (arst_n),
    .push     (res_valid),
    .din      (res),
    .pop      (send),
    .dout     (rsp),
    .empty    (empty),
    .free_cnt (free_cnt)
  );

  assign send      = !empty && (credit_cnt != '0);
  assign rsp_valid = send;

  // Two slots beyond the registered result, one for the decode register
  // and one for the command popped now.
  assign exe_ready = (int'(free_cnt) >= 2 + int'(res_valid));

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      credit_cnt <= '0;
    end else begin
      case ({rsp_credit, send})
        2'b10:   credit_cnt <= credit_cnt + 1'b1;
        2'b01:   credit_cnt <= credit_cnt - 1'b1;
        default: credit_cnt <= credit_cnt; // Grant and spend cancel.
      endcase
    end
  end

endmodule

// ==== alu_unit.sv ====
/* ALU unit top: decode, execute and result stages between two credit links. */
`timescale 1ns/1ps
`include "alu_cfg.svh"

module alu_unit (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic                    cmd_valid,
  input  alu_link_pkg::alu_cmd_t  cmd,
  output logic                    cmd_credit,
  input  logic                    rsp_credit,
  output logic                    rsp_valid,
  output alu_link_pkg::alu_rsp_t  rsp
);
  import alu_ops_pkg::*;
  import alu_link_pkg::*;

  logic                   exe_ready;
  logic                   op_valid;
  alu_op_t                op;
  logic [`ALU_WIDTH-1:0]  in1;
  logic [`ALU_WIDTH-1:0]  in2;
  logic                   res_valid;
  alu_rsp_t               res;

  alu_decode u_decode (
    .clk        (clk),
    .arst_n     (arst_n),
    .cmd_valid  (cmd_valid),
    .cmd        (cmd),
    .cmd_credit (cmd_credit),
    .exe_ready  (exe_ready),
    .op_valid   (op_valid),
    .op         (op),
    .in1        (in1),
    .in2        (in2)
  );

  alu_execute u_execute (
    .clk       (clk),
    .arst_n    (arst_n),
    .op_valid  (op_valid),
    .op        (op),
    .in1       (in1),
    .in2       (in2),
    .res_valid (res_valid),
    .res       (res)
  );

  alu_result u_result (
    .clk        (clk),
    .arst_n     (arst_n),
    .res_valid  (res_valid),
    .res        (res),
    .exe_ready  (exe_ready),
    .rsp_credit (rsp_credit),
    .rsp_valid  (rsp_valid),
    .rsp        (rsp)
  );

endmodule

// ==== credit_fifo.sv ====
/* Circular FIFO with a type-parameter payload and a free slot count. */
`timescale 1ns/1ps

module credit_fifo #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 4
) (
  input  logic                         clk,
  input  logic                         arst_n,
  input  logic                         push,
  input  payload_t                     din,
  input  logic                         pop,
  output payload_t                     dout,
  output logic                         empty,
  output logic [$clog2(DEPTH+1)-1:0]   free_cnt
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  // Wrap at DEPTH, which need not be a power of two.
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= next_ptr(wr_ptr);
      if (pop)  rd_ptr <= next_ptr(rd_ptr);
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr] <= din;
  end

  assign dout     = mem[rd_ptr];
  assign empty    = (count == '0);
  assign free_cnt = CNT_W'(DEPTH) - count;

endmodule

// ==== filelist.f ====
+incdir+.
alu_ops_pkg.sv
alu_link_pkg.sv
credit_fifo.sv
alu.sv
alu_decode.sv
alu_execute.sv
alu_result.sv
alu_unit.sv
tb_alu_unit.sv

// ==== tb_alu_model.svh ====
/* Testbench reference model of the ALU unit, LFSR stimulus source and
   expected-response queue. */
`ifndef TB_ALU_MODEL_SVH
`define TB_ALU_MODEL_SVH

logic [31:0] lfsr_state;
logic        flag_c; // Model copy of the stored carry.
logic        flag_z;
alu_rsp_t    expect_q[$];

// Galois LFSR x^32 + x^22 + x^2 + x + 1, one step per bit taken.
function automatic logic [31:0] take_bits(input int n);
  logic [31:0] bits;
  int          i;
  bits = '0;
  for (i = 0; i < n; i++) begin
    bits = {bits[30:0], lfsr_state[0]};
    lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
  end
  return bits;
endfunction

task automatic model_push(input alu_cmd_t c);
  alu_rsp_t       r;
  logic           cin;
  logic           zblk;
  logic [W:0]     sum;
  logic [2*W-1:0] wide;
  logic           sa;
  logic           sb;
  int             k;
  r         = '0;
  r.tag     = c.tag;
  r.illegal = (c.func > 4'd9);
  cin       = c.use_flags & flag_c;
  zblk      = c.use_flags & ~flag_z; // Stored Z clear blocks a new Z.
  sa        = c.in1[W-1];
  sb        = c.in2[W-1];
  r.flags.c = cin;
  case (c.func)
    4'd0: r.result = c.in1 & c.in2;
    4'd1: r.result = c.in1 | c.in2;
    4'd7: r.result = c.in1 ^ c.in2;
    4'd2: begin
      sum       = {1'b0, c.in1} + {1'b0, c.in2} + cin;
      r.result  = sum[W-1:0];
      r.flags.c = sum[W];
      r.flags.v = (sa == sb) && (r.result[W-1] != sa);
    end
    4'd3: begin
      r.result  = c.in1 - c.in2;
      r.flags.c = (c.in1 < c.in2); // Unsigned borrow.
      r.flags.v = (sa != sb) && (r.result[W-1] != sa);
    end
    4'd4: begin
      wide = '0;
      if (c.in2 <= W) wide = {{W{1'b0}}, c.in1} << c.in2;
      r.result  = wide[W-1:0];
      r.flags.c = wide[W];
    end
    4'd5, 4'd6: begin
      r.result = c.in1;
      for (k = 0; k < W && k < c.in2; k++) begin
        r.result = {(c.func == 4'd5) ? sa : 1'b0, r.result[W-1:1]};
      end
      r.flags.c = 1'b0;
    end
    4'd8: begin
      wide = {{W{sa}}, c.in1} * {{W{sb}}, c.in2}; // Sign extended, low 2W bits.
      {r.high, r.result} = wide;
      r.flags.c = 1'b0;
    end
    4'd9: begin
      wide = {{W{1'b0}}, c.in1} * {{W{1'b0}}, c.in2};
      {r.high, r.result} = wide;
      r.flags.c = 1'b0;
    end
    default: r.result = c.in1;
  endcase
  if (c.func >= 4'd4 && c.func <= 4'd6) r.flags.v = r.result[W-1] ^ r.flags.c;
  r.flags.n = r.result[W-1];
  r.flags.z = (r.result == '0) && !zblk;
  flag_c = r.flags.c;
  flag_z = r.flags.z;
  expect_q.push_back(r);
endtask

`endif

// ==== tb_alu_unit.sv ====
/* Testbench for the ALU unit: clock, reset, credit-driven stimulus,
   response checks and report. */
`timescale 1ns/1ps
`include "alu_cfg.svh"

module tb_alu_unit;
  import alu_ops_pkg::*;
  import alu_link_pkg::*;

  localparam int W = `ALU_WIDTH;

  logic     clk;
  logic     arst_n;
  logic     cmd_valid;
  alu_cmd_t cmd;
  logic     cmd_credit;
  logic     rsp_credit;
  logic     rsp_valid;
  alu_rsp_t rsp;

  int                    src_credits;
  int                    sink_granted; // Granted, not yet used by the DUT.
  bit                    sink_on;
  bit                    aborted;
  int                    errors;
  int                    checks;
  int                    rsp_count;
  logic [`ALU_TAG_W-1:0] next_tag;

  logic [W-1:0] shift_src [3] = '{32'h8000_0001, 32'h4000_0000, 32'h7F0F_1235};
  logic [W-1:0] shift_amt [8] = '{0, 1, 4, W-1, W, W+1, W+8, {W{1'b1}}};
  logic [W-1:0] mul_a [4] = '{32'hFFFF_FFFF, 32'h8000_0000, 32'hFFFF_FFFF, 32'd12345};
  logic [W-1:0] mul_b [4] = '{32'hFFFF_FFFF, 32'h8000_0000, 32'd2, 32'hFFFF_FD5A};

  `include "tb_alu_model.svh"

  alu_unit UUT (
    .clk        (clk),
    .arst_n     (arst_n),
    .cmd_valid  (cmd_valid),
    .cmd        (cmd),
    .cmd_credit (cmd_credit),
    .rsp_credit (rsp_credit),
    .rsp_valid  (rsp_valid),
    .rsp        (rsp)
  );

  always #20 clk = ~clk;

  task automatic report_field(input string name, input logic [W-1:0] got,
                              input logic [W-1:0] exp, input logic [`ALU_TAG_W-1:0] tag);
    $display("Fail %s: got 0x%0h, expected 0x%0h (tag 0x%0h)", name, got, exp, tag);
    errors++;
  endtask

  task automatic compare_rsp;
    alu_rsp_t exp;
    if (expect_q.size() == 0) begin
      $display("Error: response with tag 0x%0h arrived with no command outstanding", rsp.tag);
      errors++;
    end else begin
      exp = expect_q.pop_front();
      checks++;
      if (rsp.tag !== exp.tag) report_field("rsp.tag", rsp.tag, exp.tag, exp.tag);
      if (rsp.result !== exp.result) report_field("rsp.result", rsp.result, exp.result, exp.tag);
      if (rsp.high !== exp.high) report_field("rsp.high", rsp.high, exp.high, exp.tag);
      if (rsp.flags !== exp.flags) report_field("rsp.flags", rsp.flags, exp.flags, exp.tag);
      if (rsp.illegal !== exp.illegal)
        report_field("rsp.illegal", rsp.illegal, exp.illegal, exp.tag);
    end
  endtask

  // Sample outputs, then drive the next cycle's inputs.
  task automatic next_cycle;
    @(negedge clk);
    if (cmd_credit) begin
      src_credits++;
      if (src_credits > `ALU_CMD_DEPTH) begin
        $display("Error: source holds %0d credits, more than the input buffer depth", src_credits);
        errors++;
      end
    end
    if (rsp_valid) begin
      if (sink_granted == 0) begin
        $display("Error: response sent without a sink credit");
        errors++;
      end else begin
        sink_granted--;
      end
      rsp_count++;
      compare_rsp();
    end
    cmd_valid  = 1'b0;
    rsp_credit = 1'b0;
    if (sink_on && sink_granted < 6 && take_bits(1) != 0) begin
      rsp_credit = 1'b1;
      sink_granted++;
    end
  endtask

  task automatic drive_cmd(input logic [3:0] f, input logic [W-1:0] a,
                           input logic [W-1:0] b, input logic u);
    alu_cmd_t c;
    c.func      = f;
    c.in1       = a;
    c.in2       = b;
    c.use_flags = u;
    c.tag       = next_tag;
    next_tag++;
    cmd         = c;
    cmd_valid   = 1'b1;
    src_credits--;
    model_push(c);
  endtask

  task automatic send_cmd(input logic [3:0] f, input logic [W-1:0] a,
                          input logic [W-1:0] b, input logic u);
    int waited;
    waited = 0;
    if (aborted) return;
    next_cycle();
    while (src_credits == 0 && waited < 500) begin
      next_cycle();
      waited++;
    end
    if (src_credits == 0) begin
      $display("Error: timed out waiting for a command credit");
      errors++;
      aborted = 1'b1;
    end else begin
      drive_cmd(f, a, b, u);
    end
  endtask

  task automatic random_fields(output logic [3:0] f, output logic [W-1:0] a,
                               output logic [W-1:0] b, output logic u);
    f = 4'(take_bits(4));
    a = take_bits(W);
    b = take_bits(W);
    if (take_bits(1) != 0) b = take_bits(6); // Small shift amounts.
    u = take_bits(1) != 0;
  endtask

  task automatic wait_drain;
    int waited;
    waited = 0;
    if (aborted) return;
    while (expect_q.size() > 0 && waited < 2000) begin
      next_cycle();
      waited++;
    end
    if (expect_q.size() > 0) begin
      $display("Error: timed out with %0d responses outstanding", expect_q.size());
      errors++;
      aborted = 1'b1;
    end else if (src_credits != `ALU_CMD_DEPTH) begin
      $display("Error: source holds %0d credits after the drain, expected %0d",
               src_credits, `ALU_CMD_DEPTH);
      errors++;
    end
  endtask

  task automatic end_test(input string name, input int e0, input int c0);
    $display("Test %-12s done: %0d checks, %0d errors", name, checks - c0, errors - e0);
  endtask

  initial begin
    int           i;
    int           j;
    int           k;
    int           e0;
    int           c0;
    int           r0;
    int           r40;
    int           leftover;
    int           sent;
    logic [3:0]   f;
    logic [W-1:0] a;
    logic [W-1:0] b;
    logic         u;
    clk          = 1'b0;
    arst_n       = 1'b0;
    cmd_valid    = 1'b0;
    cmd          = '0;
    rsp_credit   = 1'b0;
    lfsr_state   = 32'd88;
    flag_c       = 1'b0;
    flag_z       = 1'b0;
    src_credits  = `ALU_CMD_DEPTH;
    sink_granted = 0;
    sink_on      = 1'b1;
    aborted      = 1'b0;
    errors       = 0;
    checks       = 0;
    rsp_count    = 0;
    next_tag     = '0;
    for (i = 0; i < 16; i++) begin
      @(negedge clk);
      if (cmd_credit || rsp_valid) begin
        $display("Error: credit or response active during reset");
        errors++;
      end
    end
    arst_n = 1'b1;

    e0 = errors;
    c0 = checks;
    send_cmd(ALU_AND, 32'h0, 32'h0, 1'b1); // Flags straight from reset.
    for (i = 0; i < 4; i++) begin
      a = take_bits(W);
      b = take_bits(W);
      send_cmd(ALU_AND, a, b, 1'b0);
      send_cmd(ALU_OR, a, b, 1'b1);
      send_cmd(ALU_XOR, a, b, 1'b0);
    end
    send_cmd(ALU_AND, 32'h0000_F0F0, 32'h0000_0F0F, 1'b0);
    for (i = 10; i < 16; i++) begin
      a = take_bits(W);
      b = take_bits(W);
      send_cmd(4'(i), a, b, take_bits(1) != 0);
    end
    wait_drain();
    end_test("logic", e0, c0);

    e0 = errors;
    c0 = checks;
    send_cmd(ALU_ADD, 32'hFFFF_FFFF, 32'h1, 1'b0);
    send_cmd(ALU_ADD, 32'h0, 32'h0, 1'b1);          // Carry in from the stored C.
    send_cmd(ALU_ADD, 32'h7FFF_FFFF, 32'h1, 1'b0);
    send_cmd(ALU_ADD, 32'h8000_0000, 32'h8000_0000, 1'b0);
    send_cmd(ALU_ADD, 32'h0, 32'h0, 1'b1);
    send_cmd(ALU_ADD, 32'hFFFF_0000, 32'h0002_0000, 1'b0);
    send_cmd(ALU_ADD, 32'h1, 32'h2, 1'b1);          // Upper half of a 64-bit add.
    send_cmd(ALU_SUB, 32'h0, 32'h1, 1'b0);
    send_cmd(ALU_SUB, 32'h8000_0000, 32'h1, 1'b0);
    send_cmd(ALU_SUB, 32'h5, 32'h5, 1'b0);
    send_cmd(ALU_ADD, 32'h0, 32'h0, 1'b1);          // Z chains through.
    send_cmd(ALU_AND, 32'h0, 32'h1234, 1'b1);
    send_cmd(ALU_SUB, 32'h3, 32'h1, 1'b0);
    send_cmd(ALU_AND, 32'h0, 32'h0, 1'b1);          // Z blocked by the stored Z.
    for (i = 0; i < 20; i++) begin
      a = take_bits(W);
      b = take_bits(W);
      send_cmd((take_bits(1) != 0) ? ALU_SUB : ALU_ADD, a, b, take_bits(1) != 0);
    end
    wait_drain();
    end_test("add/sub", e0, c0);

    e0 = errors;
    c0 = checks;
    for (j = 4; j < 7; j++) begin
      for (k = 0; k < 3; k++) begin
        for (i = 0; i < 8; i++) begin
          send_cmd(4'(j), shift_src[k], shift_amt[i], 1'b0);
        end
      end
    end
    wait_drain();
    end_test("shift", e0, c0);

    e0 = errors;
    c0 = checks;
    for (i = 0; i < 14; i++) begin
      a = (i < 4) ? mul_a[i] : take_bits(W);
      b = (i < 4) ? mul_b[i] : take_bits(W);
      send_cmd(ALU_MUL, a, b, 1'b0);
      send_cmd(ALU_MULU, a, b, 1'b0);
    end
    wait_drain();
    end_test("multiply", e0, c0);

    // Sink stalls, the pipeline fills and credits stop returning.
    e0 = errors;
    c0 = checks;
    sink_on  = 1'b0;
    leftover = sink_granted;
    r0       = rsp_count;
    r40      = 0;
    sent     = 0;
    for (i = 0; i < 60; i++) begin
      next_cycle();
      if (i == 40) r40 = rsp_count;
      if (src_credits > 0 && sent < 24) begin
        random_fields(f, a, b, u);
        drive_cmd(f, a, b, u);
        sent++;
      end
    end
    if (rsp_count - r0 > leftover) begin
      $display("Error: more responses during the stall than credits granted");
      errors++;
    end
    if (rsp_count != r40) begin
      $display("Error: response appeared while the sink held back credits");
      errors++;
    end
    if (src_credits != 0) begin
      $display("Error: input buffer returned credits while the sink was stalled");
      errors++;
    end
    sink_on = 1'b1;
    while (sent < 24) begin
      random_fields(f, a, b, u);
      send_cmd(f, a, b, u);
      sent++;
    end
    wait_drain();
    if (rsp_count - r0 != sent) begin
      $display("Error: %0d commands sent but %0d responses received", sent, rsp_count - r0);
      errors++;
    end
    end_test("stall", e0, c0);

    e0 = errors;
    c0 = checks;
    for (i = 0; i < 300; i++) begin
      random_fields(f, a, b, u);
      send_cmd(f, a, b, u);
    end
    wait_drain();
    end_test("random", e0, c0);

    // Idle tail catches stray responses.
    for (i = 0; i < 20; i++) begin
      next_cycle();
    end
    $display("Summary: 6 tests, %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule
